//--- Makefile
TOP := rack_core_tb

.PHONY: lint sim clean

# full warning set, stops on the first warning
lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

# builds with assertions on, then scans the log for the fail line
sim:
	verilator --binary --assert -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)
	obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/rack_core_props.sv
`timescale 1ns/1ps

module rack_core_props (
    input logic                              ep50trig,
    input logic                              reset_global,
    input logic                              count_valid,
    input logic [rack_pkg::N_CHANNELS-1:0]   spike_out,
    input logic [31:0]                       spike_count [rack_pkg::N_CHANNELS],
    input logic signed [31:0]                current [rack_pkg::N_CHANNELS]
);

    // count_valid is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        count_valid |=> !count_valid)
        else $error("count_valid high for two cycles in a row");

    // counts only move on the edge that raises count_valid
    a_count_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        ((spike_count[0] != $past(spike_count[0])) || (spike_count[1] != $past(spike_count[1])))
        |-> count_valid)
        else $error("spike_count changed outside a count_valid cycle");

    // one edge into reset is needed before the sync reset has landed
    a_spike_reset: assert property (@(posedge ep50trig)
        (reset_global && $past(reset_global)) |-> (spike_out == '0))
        else $error("spike_out not zero during reset");

    a_current_reset: assert property (@(posedge ep50trig)
        (reset_global && $past(reset_global)) |-> ((current[0] == 0) && (current[1] == 0)))
        else $error("current not zero during reset");

endmodule

bind rack_core rack_core_props i_rack_core_props (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .count_valid  (count_valid),
    .spike_out    (spike_out),
    .spike_count  (spike_count),
    .current      (current)
);

//--- bench/rack_core_tb.sv
`timescale 1ns/1ps

module rack_core_tb;

    localparam int         N_ROWS      = 10;
    localparam int         WAIT_LIMIT  = 60000;     // cycles, above one sim window at divider 381
    localparam int         RATE_SPAN   = 13107200;  // 200.0 in q16.16
    localparam logic [3:0] ADDR_UNUSED = 4'd5;
    localparam int         FAST_DIV    = 3;

    logic                              ep50trig;
    logic                              reset_global;
    logic                              param_strobe;
    logic [rack_pkg::PARAM_ADDR_W-1:0] param_addr;
    rack_pkg::param_word_u             param_data;
    logic signed [31:0]                rate [rack_pkg::N_CHANNELS];
    logic signed [31:0]                current [rack_pkg::N_CHANNELS];
    logic [rack_pkg::N_CHANNELS-1:0]   spike_out;
    logic [31:0]                       spike_count [rack_pkg::N_CHANNELS];
    logic                              count_valid;

    // stimulus table, one parameter load (or none) and a rate pair per row
    logic               tbl_load [N_ROWS];
    logic [3:0]         tbl_addr [N_ROWS];
    logic signed [31:0] tbl_data [N_ROWS];
    logic signed [31:0] tbl_rate [N_ROWS][2];
    logic signed [31:0] tbl_exp  [N_ROWS][2];

    logic signed [31:0] offset_m [2];  // expected register contents
    logic signed [31:0] gain_m [2];

    int seed;
    int mismatches;
    int failures;

    initial ep50trig = 1'b0;
    always #20 ep50trig = ~ep50trig;  // 40 ns period

    rack_core i_rack_core (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .param_strobe (param_strobe),
        .param_addr   (param_addr),
        .param_data   (param_data),
        .rate         (rate),
        .current      (current),
        .spike_out    (spike_out),
        .spike_count  (spike_count),
        .count_valid  (count_valid)
    );

    // floor((rate - offset) * gain) in integer units, then x64
    function automatic logic signed [31:0] model_current(input logic signed [31:0] r,
            input logic signed [31:0] off, input logic signed [31:0] g);
        logic signed [31:0] diff;
        longint             prod;
        longint             q;
        diff = r - off;
        prod = longint'(diff) * longint'(g);  // q32.32
        q = prod / 64'sd4294967296;
        if (prod < 0 && q * 64'sd4294967296 != prod) begin
            q = q - 1;  // division truncates toward zero, floor wants one lower
        end
        return 32'(q * 64);
    endfunction

    function automatic void model_load(input logic [3:0] addr, input logic signed [31:0] data);
        case (addr)
            rack_pkg::ADDR_GAIN_IA:   gain_m[0] = data;
            rack_pkg::ADDR_OFFSET_IA: offset_m[0] = data;
            rack_pkg::ADDR_OFFSET_II: offset_m[1] = data;
            rack_pkg::ADDR_GAIN_II:   gain_m[1] = data;
            default: begin
                // divider has no effect on current, unused addresses do nothing
            end
        endcase
    endfunction

    function automatic logic signed [31:0] random_rate();
        return $random(seed) % RATE_SPAN;  // within +-200.0
    endfunction

    task automatic set_row(input int idx, input logic load, input logic [3:0] addr,
            input logic signed [31:0] data, input logic signed [31:0] r0,
            input logic signed [31:0] r1);
        tbl_load[idx]    = load;
        tbl_addr[idx]    = addr;
        tbl_data[idx]    = data;
        tbl_rate[idx][0] = r0;
        tbl_rate[idx][1] = r1;
    endtask

    task automatic fill_table();
        set_row(0, 1'b0, 4'd0, 0, 663224, 663224);                      // 10.12, right at the offset
        set_row(1, 1'b0, 4'd0, 0, 1318584, 1318584);                    // 20.12
        set_row(2, 1'b1, rack_pkg::ADDR_GAIN_IA, 131072, 1318584, 1318584);   // gain 2.0 on ia
        set_row(3, 1'b1, rack_pkg::ADDR_OFFSET_II, 0, 1318584, 1318584);      // offset 0 on ii
        set_row(4, 1'b1, ADDR_UNUSED, 32'h7fff0000, 1318584, 1318584);
        set_row(5, 1'b0, 4'd0, 0, random_rate(), random_rate());
        set_row(6, 1'b0, 4'd0, 0, random_rate(), random_rate());
        set_row(7, 1'b1, rack_pkg::ADDR_GAIN_II, 32768, random_rate(), random_rate());  // 0.5
        set_row(8, 1'b0, 4'd0, 0, random_rate(), random_rate());
        set_row(9, 1'b0, 4'd0, 0, -327680, 32768);                      // -5.0 and 0.5
        offset_m[0] = rack_pkg::OFFSET_DEFAULT;
        offset_m[1] = rack_pkg::OFFSET_DEFAULT;
        gain_m[0]   = rack_pkg::GAIN_DEFAULT;
        gain_m[1]   = rack_pkg::GAIN_DEFAULT;
        for (int i = 0; i < N_ROWS; i++) begin
            if (tbl_load[i]) begin
                model_load(tbl_addr[i], tbl_data[i]);
            end
            for (int ch = 0; ch < 2; ch++) begin
                tbl_exp[i][ch] = model_current(tbl_rate[i][ch], offset_m[ch], gain_m[ch]);
            end
        end
    endtask

    task automatic load_param(input logic [3:0] addr, input logic signed [31:0] data);
        @(posedge ep50trig);
        param_strobe        <= 1'b1;
        param_addr          <= addr;
        param_data.as_fixed <= data;
        @(posedge ep50trig);
        param_strobe <= 1'b0;  // register took the word on this edge
    endtask

    task automatic apply_and_check(input int step, input logic signed [31:0] r0,
            input logic signed [31:0] r1, input logic signed [31:0] e0,
            input logic signed [31:0] e1);
        logic signed [31:0] want [2];
        want[0] = e0;
        want[1] = e1;
        @(posedge ep50trig);
        rate[0] <= r0;
        rate[1] <= r1;
        repeat (2) @(posedge ep50trig);  // difference stage, then product stage
        @(negedge ep50trig);
        for (int ch = 0; ch < 2; ch++) begin
            if (current[ch] !== want[ch]) begin
                $display("Mismatch at %0t: step %0d current[%0d] is %0d, expected %0d",
                         $time, step, ch, current[ch], want[ch]);
                mismatches++;
            end
        end
    endtask

    // spikes seen from one count_valid up to the next, and the spacing in cycles
    task automatic measure_window(output int n0, output int n1, output int len);
        int waited;
        n0 = 0;
        n1 = 0;
        len = -1;
        waited = 0;
        @(negedge ep50trig);
        while (count_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge ep50trig);
            waited++;
        end
        if (count_valid !== 1'b1) begin
            $display("Timeout at %0t: no opening count_valid within %0d cycles", $time, WAIT_LIMIT);
            failures++;
        end else begin
            n0 = n0 + int'(spike_out[0]);  // spikes beside the opening pulse go to the new window
            n1 = n1 + int'(spike_out[1]);
            waited = 0;
            @(negedge ep50trig);
            while (count_valid !== 1'b1 && waited < WAIT_LIMIT) begin
                n0 = n0 + int'(spike_out[0]);
                n1 = n1 + int'(spike_out[1]);
                @(negedge ep50trig);
                waited++;
            end
            if (count_valid !== 1'b1) begin
                $display("Timeout at %0t: no closing count_valid within %0d cycles",
                         $time, WAIT_LIMIT);
                failures++;
            end else begin
                len = waited + 1;
            end
        end
    endtask

    initial begin
        int n0;
        int n1;
        int len;
        seed         = 32'he64a_5b86;
        mismatches   = 0;
        failures     = 0;
        reset_global = 1'b1;
        param_strobe = 1'b0;
        param_addr   = '0;
        param_data   = '0;
        rate[0]      = '0;
        rate[1]      = '0;
        fill_table();

        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        if (spike_out !== 2'b00 || count_valid !== 1'b0 || current[0] !== 0 || current[1] !== 0
                || spike_count[0] !== 0 || spike_count[1] !== 0) begin
            $display("Mismatch at %0t: outputs not zero right after reset", $time);
            mismatches++;
        end

        for (int i = 0; i < N_ROWS; i++) begin
            if (tbl_load[i]) begin
                load_param(tbl_addr[i], tbl_data[i]);
            end
            apply_and_check(i, tbl_rate[i][0], tbl_rate[i][1], tbl_exp[i][0], tbl_exp[i][1]);
        end

        // faster ticks, first window may still straddle the old divider
        load_param(rack_pkg::ADDR_DIVIDER, FAST_DIV);
        measure_window(n0, n1, len);
        measure_window(n0, n1, len);
        if (len != 128 * (FAST_DIV + 1)) begin
            $display("Mismatch at %0t: count_valid spacing %0d, expected %0d",
                     $time, len, 128 * (FAST_DIV + 1));
            mismatches++;
        end

        // ia at zero current, ii negative
        apply_and_check(N_ROWS, offset_m[0], -327680,
                        model_current(offset_m[0], offset_m[0], gain_m[0]),
                        model_current(-327680, offset_m[1], gain_m[1]));
        measure_window(n0, n1, len);  // lets any spike already under way finish
        measure_window(n0, n1, len);
        if (n0 != 0 || n1 != 0 || spike_count[0] !== 0 || spike_count[1] !== 0) begin
            $display("Mismatch at %0t: spikes without drive, seen %0d/%0d, counted %0d/%0d",
                     $time, n0, n1, spike_count[0], spike_count[1]);
            mismatches++;
        end

        // strong drive on ia only
        apply_and_check(N_ROWS + 1, RATE_SPAN, 0,
                        model_current(RATE_SPAN, offset_m[0], gain_m[0]),
                        model_current(0, offset_m[1], gain_m[1]));
        measure_window(n0, n1, len);
        measure_window(n0, n1, len);
        if (n0 == 0 || spike_count[0] !== 32'(n0)) begin
            $display("Mismatch at %0t: spike_count[0] is %0d, spikes seen %0d",
                     $time, spike_count[0], n0);
            mismatches++;
        end
        if (n1 != 0 || spike_count[1] !== 0) begin
            $display("Mismatch at %0t: channel 1 spiked, seen %0d, counted %0d",
                     $time, n1, spike_count[1]);
            mismatches++;
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- project.f
source/rack_pkg.sv
source/param_bank.sv
source/tick_gen.sv
source/afferent_current.sv
source/izh_neuron.sv
source/spike_tally.sv
source/rack_core.sv
bench/rack_core_props.sv
bench/rack_core_tb.sv

//--- source/afferent_current.sv
`timescale 1ns/1ps

module afferent_current (
    input  logic                           ep50trig,
    input  logic                           reset_global,
    input  logic signed [rack_pkg::WORD_W-1:0] rate [rack_pkg::N_CHANNELS],  // q16.16 pps
    input  rack_pkg::param_word_u          offset [rack_pkg::N_CHANNELS],
    input  rack_pkg::param_word_u          gain [rack_pkg::N_CHANNELS],
    output logic signed [rack_pkg::WORD_W-1:0] current [rack_pkg::N_CHANNELS]  // int << 6
);

    // stage 1 result, rate with offset removed (q16.16)
    logic signed [rack_pkg::WORD_W-1:0]   diff [rack_pkg::N_CHANNELS];

    // full q32.32 product and its floored integer part
    logic signed [2*rack_pkg::WORD_W-1:0] product [rack_pkg::N_CHANNELS];
    logic signed [2*rack_pkg::WORD_W-1:0] whole [rack_pkg::N_CHANNELS];

    // stage 1, offset removal
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                diff[n] <= '0;
            end
        end else begin
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                diff[n] <= rate[n] - offset[n].as_fixed;  // wraps like the 32-bit datapath
            end
        end
    end

    // gain, then floor
    always_comb begin
        for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
            product[n] = diff[n] * gain[n].as_fixed;  // signed, evaluated at 64 bits
            // arithmetic shift drops the fraction, so negatives round down
            whole[n] = product[n] >>> (2 * rack_pkg::FRAC_BITS);
        end
    end

    // stage 2, integer into neuron fixed point
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                current[n] <= '0;
            end
        end else begin
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                current[n] <= whole[n][rack_pkg::WORD_W-1:0] <<< rack_pkg::FIXED_SHIFT;
            end
        end
    end

endmodule

//--- source/izh_neuron.sv
`timescale 1ns/1ps

module izh_neuron (
    input  logic                               ep50trig,
    input  logic                               reset_global,
    input  logic                               neuron_tick,  // one euler step per pulse
    input  logic signed [rack_pkg::WORD_W-1:0] current,      // int << 6
    output logic                               spike_pulse
);

    // membrane potential and recovery, both x1024
    logic signed [rack_pkg::WORD_W-1:0]   v;
    logic signed [rack_pkg::WORD_W-1:0]   u;

    // 64-bit working copies
    logic signed [2*rack_pkg::WORD_W-1:0] v_w;
    logic signed [2*rack_pkg::WORD_W-1:0] u_w;
    logic signed [2*rack_pkg::WORD_W-1:0] i_w;
    logic signed [2*rack_pkg::WORD_W-1:0] quad;
    logic signed [2*rack_pkg::WORD_W-1:0] dv;
    logic signed [2*rack_pkg::WORD_W-1:0] du;
    logic signed [2*rack_pkg::WORD_W-1:0] v_next;
    logic signed [2*rack_pkg::WORD_W-1:0] u_next;
    logic signed [2*rack_pkg::WORD_W-1:0] v_store;
    logic signed [2*rack_pkg::WORD_W-1:0] u_store;
    logic                                 crossed;

    always_comb begin
        v_w = {{rack_pkg::WORD_W{v[rack_pkg::WORD_W-1]}}, v};
        u_w = {{rack_pkg::WORD_W{u[rack_pkg::WORD_W-1]}}, u};
        i_w = {{rack_pkg::WORD_W{current[rack_pkg::WORD_W-1]}}, current};
        i_w = i_w <<< (rack_pkg::V_SCALE_SHIFT - rack_pkg::FIXED_SHIFT);  // x64 -> x1024

        // 0.04 v^2, one 1024 from the scaling and one from the q10 coefficient
        quad = (v_w * v_w * rack_pkg::IZH_K2_Q10) >>> (2 * rack_pkg::V_SCALE_SHIFT);
        dv   = quad + v_w * rack_pkg::IZH_K1 + rack_pkg::IZH_K0_SCALED - u_w + i_w;

        // dt = 1/128 ms, one neuron tick
        v_next = v_w + (dv >>> $clog2(rack_pkg::TICKS_PER_SIM));

        // a (b v - u), kept at q20 until the final shift to hold precision
        du = (v_w * rack_pkg::IZH_B_Q10 - (u_w <<< rack_pkg::V_SCALE_SHIFT))
             * rack_pkg::IZH_A_Q10;
        du = du >>> (2 * rack_pkg::V_SCALE_SHIFT + $clog2(rack_pkg::TICKS_PER_SIM));
        u_next = u_w + du;

        crossed = (v_next >= rack_pkg::THRESHOLD_SCALED);

        if (crossed) begin
            v_store = rack_pkg::V_RESET_SCALED;     // v <- c
            u_store = u_next + rack_pkg::U_JUMP_SCALED;  // u <- u + d
        end else if (v_next < rack_pkg::V_FLOOR_SCALED) begin
            v_store = rack_pkg::V_FLOOR_SCALED;     // keeps strong inhibition from diverging
            u_store = u_next;
        end else begin
            v_store = v_next;
            u_store = u_next;
        end
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            v           <= rack_pkg::V_RESET_SCALED;
            u           <= rack_pkg::U_RESET_SCALED;
            spike_pulse <= 1'b0;
        end else begin
            spike_pulse <= neuron_tick && crossed;  // high for the cycle after the step
            if (neuron_tick) begin
                v <= v_store[rack_pkg::WORD_W-1:0];  // bounded by floor and threshold
                u <= u_store[rack_pkg::WORD_W-1:0];
            end
        end
    end

endmodule

//--- source/param_bank.sv
`timescale 1ns/1ps

module param_bank (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              param_strobe,   // one-cycle load pulse
    input  logic [rack_pkg::PARAM_ADDR_W-1:0] param_addr,
    input  rack_pkg::param_word_u             param_data,
    output rack_pkg::param_word_u             offset [rack_pkg::N_CHANNELS],
    output rack_pkg::param_word_u             gain [rack_pkg::N_CHANNELS],
    output rack_pkg::param_word_u             divider
);

    // five registers, loaded one cycle after the strobe
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                offset[n].as_fixed <= rack_pkg::OFFSET_DEFAULT;  // 10.12 on both channels
                gain[n].as_fixed   <= rack_pkg::GAIN_DEFAULT;    // unity gain
            end
            divider.as_count <= rack_pkg::DIVIDER_DEFAULT;
        end else if (param_strobe) begin
            // ia sits at channel 0, ii at channel 1
            case (param_addr)
                rack_pkg::ADDR_GAIN_IA: begin
                    gain[0] <= param_data;
                end
                rack_pkg::ADDR_OFFSET_IA: begin
                    offset[0] <= param_data;
                end
                rack_pkg::ADDR_OFFSET_II: begin
                    offset[1] <= param_data;
                end
                rack_pkg::ADDR_DIVIDER: begin
                    divider <= param_data;  // picked up by tick_gen at its next wrap
                end
                rack_pkg::ADDR_GAIN_II: begin
                    gain[1] <= param_data;
                end
                default: begin
                    // unmapped address, strobe ignored
                end
            endcase
        end
    end

endmodule

//--- source/rack_core.sv
`timescale 1ns/1ps

module rack_core (
    input  logic                               ep50trig,
    input  logic                               reset_global,
    input  logic                               param_strobe,
    input  logic [rack_pkg::PARAM_ADDR_W-1:0]  param_addr,
    input  rack_pkg::param_word_u              param_data,
    input  logic signed [rack_pkg::WORD_W-1:0] rate [rack_pkg::N_CHANNELS],     // ia, ii
    output logic signed [rack_pkg::WORD_W-1:0] current [rack_pkg::N_CHANNELS],
    output logic [rack_pkg::N_CHANNELS-1:0]    spike_out,
    output logic [rack_pkg::WORD_W-1:0]        spike_count [rack_pkg::N_CHANNELS],
    output logic                               count_valid
);

    rack_pkg::param_word_u offset [rack_pkg::N_CHANNELS];
    rack_pkg::param_word_u gain [rack_pkg::N_CHANNELS];
    rack_pkg::param_word_u divider;
    logic                  neuron_tick;
    logic                  sim_tick;

    param_bank i_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .param_strobe (param_strobe),
        .param_addr   (param_addr),
        .param_data   (param_data),
        .offset       (offset),
        .gain         (gain),
        .divider      (divider)
    );

    tick_gen i_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .divider      (divider),
        .neuron_tick  (neuron_tick),
        .sim_tick     (sim_tick)
    );

    // rate -> current, two cycles of latency
    afferent_current i_afferent_current (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate         (rate),
        .offset       (offset),
        .gain         (gain),
        .current      (current)
    );

    // one neuron per afferent channel
    for (genvar n = 0; n < rack_pkg::N_CHANNELS; n++) begin : g_neuron
        izh_neuron i_izh_neuron (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .neuron_tick  (neuron_tick),
            .current      (current[n]),
            .spike_pulse  (spike_out[n])
        );
    end

    spike_tally i_spike_tally (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .spike_in     (spike_out),
        .sim_tick     (sim_tick),
        .spike_count  (spike_count),
        .count_valid  (count_valid)
    );

endmodule

//--- source/rack_pkg.sv
package rack_pkg;

    // widths and counts
    localparam int WORD_W       = 32;   // rate, offset, gain, current and count words
    localparam int N_CHANNELS   = 2;    // 0 = Ia, 1 = II
    localparam int PARAM_ADDR_W = 4;

    // parameter register addresses, one per trigger bit
    localparam logic [PARAM_ADDR_W-1:0] ADDR_GAIN_IA   = 4'd1;
    localparam logic [PARAM_ADDR_W-1:0] ADDR_OFFSET_IA = 4'd3;
    localparam logic [PARAM_ADDR_W-1:0] ADDR_OFFSET_II = 4'd6;
    localparam logic [PARAM_ADDR_W-1:0] ADDR_DIVIDER   = 4'd7;
    localparam logic [PARAM_ADDR_W-1:0] ADDR_GAIN_II   = 4'd10;

    // reset defaults
    localparam logic signed [WORD_W-1:0] OFFSET_DEFAULT  = 32'sd663224;  // 10.12 in q16.16
    localparam logic signed [WORD_W-1:0] GAIN_DEFAULT    = 32'sd65536;   // 1.0
    localparam logic [WORD_W-1:0]        DIVIDER_DEFAULT = 32'd381;      // half real-time speed

    // fixed point
    localparam int FRAC_BITS     = 16;  // q16.16 words
    localparam int FIXED_SHIFT   = 6;   // integer -> neuron current
    localparam int V_SCALE_SHIFT = 10;  // potentials x1024, coefficients q10

    // tick ratio, neuron ticks per 1 ms simulation tick
    localparam logic [WORD_W-1:0] TICKS_PER_SIM = 32'd128;

    // izhikevich regular spiking, all in x1024 units
    localparam logic signed [WORD_W-1:0] THRESHOLD_SCALED = 32'sd30720;    // 30 mV
    localparam logic signed [WORD_W-1:0] V_RESET_SCALED   = -32'sd66560;   // c = -65 mV
    localparam logic signed [WORD_W-1:0] U_RESET_SCALED   = -32'sd13312;   // b * c
    localparam logic signed [WORD_W-1:0] U_JUMP_SCALED    = 32'sd8192;     // d = 8
    localparam logic signed [WORD_W-1:0] V_FLOOR_SCALED   = -32'sd102400;  // -100 mV wall
    localparam logic signed [WORD_W-1:0] IZH_K2_Q10       = 32'sd41;       // 0.04
    localparam logic signed [WORD_W-1:0] IZH_K1           = 32'sd5;
    localparam logic signed [WORD_W-1:0] IZH_K0_SCALED    = 32'sd143360;   // 140
    localparam logic signed [WORD_W-1:0] IZH_A_Q10        = 32'sd20;       // a ~ 0.02
    localparam logic signed [WORD_W-1:0] IZH_B_Q10        = 32'sd205;      // b ~ 0.2

    // one parameter word, decoded as q16.16 or as a plain count
    typedef union packed {
        logic signed [WORD_W-1:0] as_fixed;  // offsets and gains
        logic [WORD_W-1:0]        as_count;  // clock divider
    } param_word_u;

endpackage

//--- source/spike_tally.sv
`timescale 1ns/1ps

module spike_tally (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [rack_pkg::N_CHANNELS-1:0]   spike_in,     // one bit per neuron
    input  logic                              sim_tick,
    output logic [rack_pkg::WORD_W-1:0]       spike_count [rack_pkg::N_CHANNELS],
    output logic                              count_valid   // one cycle after sim_tick
);

    logic [rack_pkg::WORD_W-1:0] run_count [rack_pkg::N_CHANNELS];  // spikes since last tick
    logic [rack_pkg::WORD_W-1:0] run_next [rack_pkg::N_CHANNELS];

    // a spike arriving with sim_tick still belongs to the closing window
    always_comb begin
        for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
            run_next[n] = run_count[n] + {{(rack_pkg::WORD_W-1){1'b0}}, spike_in[n]};
        end
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            count_valid <= 1'b0;
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                run_count[n]   <= '0;
                spike_count[n] <= '0;
            end
        end else begin
            count_valid <= sim_tick;
            for (int n = 0; n < rack_pkg::N_CHANNELS; n++) begin
                if (sim_tick) begin
                    spike_count[n] <= run_next[n];  // held until the next sim tick
                    run_count[n]   <= '0;
                end else begin
                    run_count[n] <= run_next[n];
                end
            end
        end
    end

endmodule

//--- source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  rack_pkg::param_word_u divider,       // half count, read as unsigned
    output logic                  neuron_tick,   // one cycle every divider+1 clocks
    output logic                  sim_tick       // every 128th neuron tick
);

    logic [rack_pkg::WORD_W-1:0] clk_cnt;   // clocks within one neuron tick
    logic [rack_pkg::WORD_W-1:0] div_hold;  // divider in use for the current period
    logic [rack_pkg::WORD_W-1:0] tick_cnt;  // neuron ticks within one sim tick
    logic                        wrap;
    logic                        sim_wrap;

    assign wrap     = (clk_cnt == div_hold);
    assign sim_wrap = (tick_cnt == rack_pkg::TICKS_PER_SIM - 32'd1);

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            clk_cnt     <= '0;
            div_hold    <= rack_pkg::DIVIDER_DEFAULT;  // same value param_bank resets to
            tick_cnt    <= '0;
            neuron_tick <= 1'b0;
            sim_tick    <= 1'b0;
        end else begin
            neuron_tick <= wrap;
            sim_tick    <= wrap && sim_wrap;  // lands on the same edge as neuron_tick
            if (wrap) begin
                clk_cnt  <= '0;
                div_hold <= divider.as_count;  // new divider only at a period boundary
                if (sim_wrap) begin
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 32'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 32'd1;
            end
        end
    end

endmodule
